/* rtl/hazard_pkg.sv */
package hazard_pkg;

    // widths that carry meaning
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [11:0] offset_t;    // signed load/store immediate
    typedef logic [15:0] cfg_data_t;
    typedef logic [1:0]  cfg_addr_t;
    typedef logic [15:0] stall_cnt_t; // wraps at 2^16

    // rv64i major opcodes
    localparam logic [6:0] OP_LOAD      = 7'b0000011;
    localparam logic [6:0] OP_STORE     = 7'b0100011;
    localparam logic [6:0] OP_OP        = 7'b0110011;
    localparam logic [6:0] OP_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_OP_32     = 7'b0111011;
    localparam logic [6:0] OP_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OP_BRANCH    = 7'b1100011;
    localparam logic [6:0] OP_LUI       = 7'b0110111;
    localparam logic [6:0] OP_AUIPC     = 7'b0010111;
    localparam logic [6:0] OP_JAL       = 7'b1101111;
    localparam logic [6:0] OP_JALR      = 7'b1100111;

    // register port map
    localparam cfg_addr_t CFG_CTRL         = 2'd0;
    localparam cfg_addr_t CFG_CNT_LOAD_USE = 2'd1;
    localparam cfg_addr_t CFG_CNT_WB       = 2'd2;
    localparam cfg_addr_t CFG_CNT_ALIAS    = 2'd3;

    // decoded instruction, also the per-stage record
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      uses_rs1;
        logic      uses_rs2;
        logic      writes_rd; // never set for x0
        logic      is_load;
        logic      is_store;
        offset_t   offset;
    } dec_info_t;

    typedef struct packed {
        logic load_use;
        logic wb_conflict;
        logic store_alias;
    } hazard_cause_t;

    typedef struct packed {
        logic alias_en;  // resets to 1
        logic rf_bypass; // resets to 0
    } hazard_cfg_t;

endpackage

/* rtl/id_decode.sv */
`timescale 1ns/1ps

module id_decode (
    input  logic                  id_valid,
    input  hazard_pkg::inst_t     id_inst,
    output hazard_pkg::dec_info_t id_info
);
    import hazard_pkg::*;

    logic [6:0] opcode;
    reg_addr_t  rd_f;
    reg_addr_t  rs1_f;
    reg_addr_t  rs2_f;
    logic       use_rs1;
    logic       use_rs2;
    logic       use_rd;
    logic       load_op;
    logic       store_op;
    offset_t    imm_i;
    offset_t    imm_s;

    // raw fields
    assign opcode = id_inst[6:0];
    assign rd_f   = id_inst[11:7];
    assign rs1_f  = id_inst[19:15];
    assign rs2_f  = id_inst[24:20];
    assign imm_i  = id_inst[31:20];
    assign imm_s  = {id_inst[31:25], id_inst[11:7]}; // split s-type immediate

    // operand usage per opcode
    always_comb begin
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        use_rd   = 1'b0;
        load_op  = 1'b0;
        store_op = 1'b0;
        case (opcode)
            OP_OP, OP_OP_32: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                use_rd  = 1'b1;
            end
            OP_OP_IMM, OP_OP_IMM_32, OP_JALR: begin
                use_rs1 = 1'b1;
                use_rd  = 1'b1;
            end
            OP_LOAD: begin
                use_rs1 = 1'b1;
                use_rd  = 1'b1;
                load_op = 1'b1;
            end
            OP_STORE: begin
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                store_op = 1'b1;
            end
            OP_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            OP_LUI, OP_AUIPC, OP_JAL: use_rd = 1'b1;
            default: ; // unknown opcode touches nothing
        endcase
    end

    // unused fields forced to zero for opcode-free compares downstream
    always_comb begin
        id_info           = '0;
        id_info.valid     = id_valid;
        id_info.uses_rs1  = use_rs1;
        id_info.uses_rs2  = use_rs2;
        id_info.rs1       = use_rs1 ? rs1_f : '0;
        id_info.rs2       = use_rs2 ? rs2_f : '0;
        id_info.rd        = use_rd ? rd_f : '0;
        id_info.writes_rd = use_rd && (rd_f != '0); // x0 writes are dropped
        id_info.is_load   = load_op;
        id_info.is_store  = store_op;
        if (load_op) begin
            id_info.offset = imm_i;
        end else if (store_op) begin
            id_info.offset = imm_s;
        end
    end

endmodule

/* rtl/stage_tracker.sv */
`timescale 1ns/1ps

module stage_tracker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  hazard_pkg::dec_info_t id_info,
    output hazard_pkg::dec_info_t ex_rec,
    output hazard_pkg::dec_info_t wb_rec
);
    import hazard_pkg::*;

    dec_info_t ex_q;
    dec_info_t mem_q; // no rule looks at mem, kept for the shift
    dec_info_t wb_q;
    dec_info_t ex_next;

    // bubble into ex on stall or empty decode slot
    always_comb begin
        if (!stall && id_info.valid) begin
            ex_next = id_info;
        end else begin
            ex_next = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_q  <= '0;
            mem_q <= '0;
            wb_q  <= '0;
        end else begin
            wb_q  <= mem_q; // older stages always drain
            mem_q <= ex_q;
            ex_q  <= ex_next;
        end
    end

    assign ex_rec = ex_q;
    assign wb_rec = wb_q;

endmodule

/* rtl/hazard_detect.sv */
`timescale 1ns/1ps

module hazard_detect (
    input  hazard_pkg::dec_info_t     ex_rec,
    input  hazard_pkg::dec_info_t     wb_rec,
    input  hazard_pkg::dec_info_t     id_info,
    input  hazard_pkg::hazard_cfg_t   cfg,
    output logic                      stall,
    output hazard_pkg::hazard_cause_t cause
);

    logic rs1_hits_ex;
    logic rs2_hits_ex;
    logic rs1_hits_wb;
    logic rs2_hits_wb;
    logic base_same;
    logic offset_same;
    logic load_use_raw;
    logic wb_conflict_raw;
    logic store_alias_raw;

    // source compares against ex
    assign rs1_hits_ex = id_info.uses_rs1 && (id_info.rs1 != '0)
                      && ex_rec.writes_rd && (id_info.rs1 == ex_rec.rd);
    assign rs2_hits_ex = id_info.uses_rs2 && (id_info.rs2 != '0)
                      && ex_rec.writes_rd && (id_info.rs2 == ex_rec.rd);

    // source compares against wb
    assign rs1_hits_wb = id_info.uses_rs1 && (id_info.rs1 != '0)
                      && wb_rec.writes_rd && (id_info.rs1 == wb_rec.rd);
    assign rs2_hits_wb = id_info.uses_rs2 && (id_info.rs2 != '0)
                      && wb_rec.writes_rd && (id_info.rs2 == wb_rec.rd);

    // load result not ready until mem
    assign load_use_raw = ex_rec.is_load && (rs1_hits_ex || rs2_hits_ex);

    // without write-through the read in decode sees the old value
    assign wb_conflict_raw = !cfg.rf_bypass && (rs1_hits_wb || rs2_hits_wb);

    // only base register number and offset are known at decode
    assign base_same   = (id_info.rs1 == ex_rec.rs1);
    assign offset_same = (id_info.offset == ex_rec.offset);

    assign store_alias_raw = cfg.alias_en && ex_rec.is_store && id_info.is_load
                          && base_same && offset_same;

    // one-hot by priority, gated by the decode strobe
    always_comb begin
        cause = '0;
        if (id_info.valid) begin
            if (load_use_raw) begin
                cause.load_use = 1'b1;
            end else if (wb_conflict_raw) begin
                cause.wb_conflict = 1'b1;
            end else if (store_alias_raw) begin
                cause.store_alias = 1'b1;
            end
        end
    end

    assign stall = cause.load_use | cause.wb_conflict | cause.store_alias;

endmodule

/* rtl/hazard_cfg_regs.sv */
`timescale 1ns/1ps

module hazard_cfg_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cfg_we,
    input  hazard_pkg::cfg_addr_t     cfg_addr,
    input  hazard_pkg::cfg_data_t     cfg_wdata,
    output hazard_pkg::cfg_data_t     cfg_rdata,
    input  hazard_pkg::hazard_cause_t cause,
    output hazard_pkg::hazard_cfg_t   cfg
);
    import hazard_pkg::*;

    hazard_cfg_t cfg_q;
    stall_cnt_t  cnt_q [3]; // load-use, wb, alias
    logic [2:0]  cnt_inc;
    logic [2:0]  cnt_clr;

    assign cnt_inc = {cause.store_alias, cause.wb_conflict, cause.load_use};

    assign cnt_clr[0] = cfg_we && (cfg_addr == CFG_CNT_LOAD_USE);
    assign cnt_clr[1] = cfg_we && (cfg_addr == CFG_CNT_WB);
    assign cnt_clr[2] = cfg_we && (cfg_addr == CFG_CNT_ALIAS);

    // policy bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q.alias_en  <= 1'b1;
            cfg_q.rf_bypass <= 1'b0;
        end else if (cfg_we && (cfg_addr == CFG_CTRL)) begin
            cfg_q.alias_en  <= cfg_wdata[0];
            cfg_q.rf_bypass <= cfg_wdata[1];
        end
    end

    // stall counters where a write clears and beats the increment
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 3; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (cnt_clr[i]) begin
                    cnt_q[i] <= '0;
                end else if (cnt_inc[i]) begin
                    cnt_q[i] <= cnt_q[i] + 16'd1; // wraps
                end
            end
        end
    end

    // combinational read mux
    always_comb begin
        case (cfg_addr)
            CFG_CTRL:         cfg_rdata = cfg_data_t'({cfg_q.rf_bypass, cfg_q.alias_en});
            CFG_CNT_LOAD_USE: cfg_rdata = cnt_q[0];
            CFG_CNT_WB:       cfg_rdata = cnt_q[1];
            default:          cfg_rdata = cnt_q[2];
        endcase
    end

    assign cfg = cfg_q;

endmodule

/* rtl/hazard_top.sv */
`timescale 1ns/1ps

module hazard_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      id_valid,
    input  hazard_pkg::inst_t         id_inst,
    input  logic                      cfg_we,
    input  hazard_pkg::cfg_addr_t     cfg_addr,
    input  hazard_pkg::cfg_data_t     cfg_wdata,
    output hazard_pkg::cfg_data_t     cfg_rdata,
    output logic                      stall,
    output hazard_pkg::hazard_cause_t cause
);
    import hazard_pkg::*;

    dec_info_t   id_info;
    dec_info_t   ex_rec;
    dec_info_t   wb_rec;
    hazard_cfg_t cfg;

    id_decode decode_i (
        .id_valid (id_valid),
        .id_inst  (id_inst),
        .id_info  (id_info)
    );

    // stall also feeds the bubble insertion
    stage_tracker tracker_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall   (stall),
        .id_info (id_info),
        .ex_rec  (ex_rec),
        .wb_rec  (wb_rec)
    );

    hazard_detect detect_i (
        .ex_rec  (ex_rec),
        .wb_rec  (wb_rec),
        .id_info (id_info),
        .cfg     (cfg),
        .stall   (stall),
        .cause   (cause)
    );

    hazard_cfg_regs regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .cause     (cause),
        .cfg       (cfg)
    );

endmodule

/* bench/tb_hazard.sv */
`timescale 1ns/1ps

module tb_hazard;
    import hazard_pkg::*;

    localparam int TOTAL_INST  = 6000;                // instructions over all streams
    localparam int CYCLE_LIMIT = TOTAL_INST * 4 + 200;

    logic          clk;
    logic          rst_n;
    logic          id_valid;
    inst_t         id_inst;
    logic          cfg_we;
    cfg_addr_t     cfg_addr;
    cfg_data_t     cfg_wdata;
    cfg_data_t     cfg_rdata;
    logic          stall;
    hazard_cause_t cause;

    // reference state
    dec_info_t   m_ex;
    dec_info_t   m_mem;
    dec_info_t   m_wb;
    logic        m_alias_en;
    logic        m_rf_bypass;
    stall_cnt_t  m_cnt [3];    // load-use, wb, alias
    int          seen [3];     // causes observed in the current test
    int          accepted;
    logic        hold;
    cfg_data_t   last_rdata;
    int          errors;
    int          n_pass;
    int          n_fail;
    int          cycle_cnt;
    logic        prev_store;
    reg_addr_t   last_base;
    offset_t     last_off;

    hazard_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .id_valid  (id_valid),
        .id_inst   (id_inst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .stall     (stall),
        .cause     (cause)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation failed");
        $finish;
    end

    // register usage by opcode, straight from the isa tables
    function automatic dec_info_t decode_ref(input logic v, input inst_t w);
        dec_info_t  r;
        logic [6:0] op;
        logic [2:0] use_bits; // rs1, rs2, rd
        op = w[6:0];
        r  = '0;
        case (op)
            OP_OP, OP_OP_32:                            use_bits = 3'b111;
            OP_OP_IMM, OP_OP_IMM_32, OP_LOAD, OP_JALR: use_bits = 3'b101;
            OP_STORE, OP_BRANCH:                        use_bits = 3'b110;
            OP_LUI, OP_AUIPC, OP_JAL:                   use_bits = 3'b001;
            default:                                    use_bits = 3'b000;
        endcase
        r.valid     = v;
        r.uses_rs1  = use_bits[2];
        r.uses_rs2  = use_bits[1];
        r.rs1       = use_bits[2] ? w[19:15] : 5'd0;
        r.rs2       = use_bits[1] ? w[24:20] : 5'd0;
        r.rd        = use_bits[0] ? w[11:7] : 5'd0;
        r.writes_rd = use_bits[0] && (w[11:7] != 5'd0);
        r.is_load   = (op == OP_LOAD);
        r.is_store  = (op == OP_STORE);
        if (r.is_load) begin
            r.offset = w[31:20];
        end else if (r.is_store) begin
            r.offset = {w[31:25], w[11:7]};
        end
        return r;
    endfunction

    function automatic logic src_hits(input logic used, input reg_addr_t src,
                                      input dec_info_t stage);
        return used && (src != 5'd0) && stage.writes_rd && (src == stage.rd);
    endfunction

    function automatic hazard_cause_t cause_ref(input dec_info_t d);
        hazard_cause_t c;
        logic          lu;
        logic          wb;
        logic          al;
        c  = '0;
        lu = m_ex.is_load && (src_hits(d.uses_rs1, d.rs1, m_ex)
                              || src_hits(d.uses_rs2, d.rs2, m_ex));
        wb = !m_rf_bypass && (src_hits(d.uses_rs1, d.rs1, m_wb)
                              || src_hits(d.uses_rs2, d.rs2, m_wb));
        al = m_alias_en && m_ex.is_store && d.is_load
             && (d.rs1 == m_ex.rs1) && (d.offset == m_ex.offset);
        if (d.valid) begin
            if (lu) begin
                c.load_use = 1'b1;
            end else if (wb) begin
                c.wb_conflict = 1'b1;
            end else if (al) begin
                c.store_alias = 1'b1;
            end
        end
        return c;
    endfunction

    function automatic logic [6:0] opcode_pick(input int unsigned sel);
        case (sel)
            0:       return OP_LOAD;
            1:       return OP_STORE;
            2:       return OP_OP;
            3:       return OP_OP_IMM;
            4:       return OP_OP_32;
            5:       return OP_OP_IMM_32;
            6:       return OP_BRANCH;
            7:       return OP_LUI;
            8:       return OP_AUIPC;
            9:       return OP_JAL;
            default: return OP_JALR;
        endcase
    endfunction

    // sample before the edge, then advance the reference with the same inputs
    task automatic step_and_check(input string name);
        dec_info_t     d;
        hazard_cause_t exp_c;
        logic          exp_s;
        logic [2:0]    inc;
        @(negedge clk);
        d     = decode_ref(id_valid, id_inst);
        exp_c = cause_ref(d);
        exp_s = exp_c.load_use | exp_c.wb_conflict | exp_c.store_alias;
        if (stall !== exp_s) begin
            $display("MISMATCH %s stall expected %0b actual %0b", name, exp_s, stall);
            errors++;
        end
        if (cause !== exp_c) begin
            $display("MISMATCH %s cause expected %03b actual %03b", name, exp_c, cause);
            errors++;
        end
        last_rdata = cfg_rdata;
        inc = {cause.store_alias, cause.wb_conflict, cause.load_use};
        for (int i = 0; i < 3; i++) begin
            if (inc[i]) begin
                seen[i]++;
            end
        end
        inc = {exp_c.store_alias, exp_c.wb_conflict, exp_c.load_use};
        for (int i = 0; i < 3; i++) begin
            if (cfg_we && (cfg_addr == cfg_addr_t'(i + 1))) begin
                m_cnt[i] = '0; // clear beats the increment
            end else if (inc[i]) begin
                m_cnt[i] = m_cnt[i] + 16'd1;
            end
        end
        if (cfg_we && (cfg_addr == CFG_CTRL)) begin
            m_alias_en  = cfg_wdata[0];
            m_rf_bypass = cfg_wdata[1];
        end
        m_wb  = m_mem;
        m_mem = m_ex;
        m_ex  = (!exp_s && d.valid) ? d : '0; // bubble on stall
        if (!exp_s && d.valid) begin
            accepted++;
        end
        hold = exp_s;
        @(posedge clk);
        #1;
    endtask

    task automatic gen_inst(input logic bias, output logic v, output inst_t w);
        logic [31:0] r;
        logic [31:0] q;
        logic [6:0]  op;
        offset_t     off;
        reg_addr_t   a_rd;
        reg_addr_t   a_rs1;
        reg_addr_t   a_rs2;
        r     = $urandom;
        q     = $urandom;
        a_rd  = {3'b000, r[1:0]}; // x0..x3 only
        a_rs1 = {3'b000, r[3:2]};
        a_rs2 = {3'b000, r[5:4]};
        off   = q[11:0];
        op    = opcode_pick($urandom_range(10));
        if (bias && prev_store && q[12]) begin
            op    = OP_LOAD; // same base and offset as the store ahead
            a_rs1 = last_base;
            off   = last_off;
        end else if (bias && q[13] && q[14]) begin
            op = OP_STORE;
        end
        case (op)
            OP_LOAD:  w = {off, a_rs1, r[14:12], a_rd, op};
            OP_STORE: w = {off[11:5], a_rs2, a_rs1, r[14:12], off[4:0], op};
            default:  w = {r[31:25], a_rs2, a_rs1, r[14:12], a_rd, op};
        endcase
        v          = (q[17:15] != 3'b000);
        prev_store = v && (op == OP_STORE);
        last_base  = a_rs1;
        last_off   = off;
    endtask

    task automatic run_stream(input string name, input int n, input logic bias);
        int    start;
        logic  v;
        inst_t w;
        start = accepted;
        while (accepted - start < n) begin
            if (!hold) begin
                gen_inst(bias, v, w);
                id_valid = v;
                id_inst  = w;
            end
            step_and_check(name);
        end
        id_valid = 1'b0;
    endtask

    task automatic read_reg(input string name, input cfg_addr_t a, input cfg_data_t exp);
        id_valid = 1'b0;
        cfg_addr = a;
        step_and_check(name);
        if (last_rdata !== exp) begin
            $display("MISMATCH %s reg %0d expected %0h actual %0h", name, a, exp, last_rdata);
            errors++;
        end
    endtask

    task automatic write_reg(input string name, input cfg_addr_t a, input cfg_data_t data);
        id_valid  = 1'b0;
        cfg_we    = 1'b1;
        cfg_addr  = a;
        cfg_wdata = data;
        step_and_check(name);
        cfg_we    = 1'b0;
    endtask

    // read all counters, then clear one and read it back
    task automatic verify_counters(input string name, input int clr);
        for (int i = 0; i < 3; i++) begin
            read_reg(name, cfg_addr_t'(i + 1), m_cnt[i]);
        end
        write_reg(name, cfg_addr_t'(clr + 1), 16'($urandom));
        read_reg(name, cfg_addr_t'(clr + 1), 16'h0000);
    endtask

    task automatic end_test(input string name, input int start_err);
        if (errors == start_err) begin
            n_pass++;
            $display("test %s: PASS", name);
        end else begin
            n_fail++;
            $display("test %s: FAIL with %0d errors", name, errors - start_err);
        end
    endtask

    task automatic clear_seen();
        for (int i = 0; i < 3; i++) begin
            seen[i] = 0;
        end
    endtask

    initial begin
        int start_err;
        void'($urandom(32'hdd4d_ac11));
        rst_n       = 1'b0;
        id_valid    = 1'b0;
        id_inst     = '0;
        cfg_we      = 1'b0;
        cfg_addr    = CFG_CTRL;
        cfg_wdata   = '0;
        m_ex        = '0;
        m_mem       = '0;
        m_wb        = '0;
        m_alias_en  = 1'b1;
        m_rf_bypass = 1'b0;
        for (int i = 0; i < 3; i++) begin
            m_cnt[i] = '0;
        end
        clear_seen();
        accepted   = 0;
        hold       = 1'b0;
        errors     = 0;
        n_pass     = 0;
        n_fail     = 0;
        prev_store = 1'b0;
        last_base  = '0;
        last_off   = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle after reset
        start_err = errors;
        repeat (12) step_and_check("reset");
        read_reg("reset", CFG_CTRL, 16'h0001);
        verify_counters("reset", 0);
        end_test("reset", start_err);

        start_err = errors;
        clear_seen();
        run_stream("load_use_drain", 2000, 1'b0);
        verify_counters("load_use_drain", 1);
        end_test("load_use_drain", start_err);

        // write-through on, wb conflicts must vanish
        start_err = errors;
        write_reg("write_through", CFG_CTRL, 16'h0003);
        clear_seen();
        run_stream("write_through", 2000, 1'b0);
        if (seen[1] != 0) begin
            $display("write_through: wb conflict seen %0d times with write-through on", seen[1]);
            errors++;
        end
        if (seen[0] == 0) begin
            $display("write_through: load-use never fired");
            errors++;
        end
        verify_counters("write_through", 2);
        end_test("write_through", start_err);

        start_err = errors;
        write_reg("alias_policy", CFG_CTRL, 16'h0001);
        clear_seen();
        run_stream("alias_policy", 1000, 1'b1);
        if (seen[2] == 0) begin
            $display("alias_policy: store alias never fired with the check enabled");
            errors++;
        end
        write_reg("alias_policy", CFG_CTRL, 16'h0000);
        clear_seen();
        run_stream("alias_policy", 1000, 1'b1);
        if (seen[2] != 0) begin
            $display("alias_policy: store alias seen %0d times with the check off", seen[2]);
            errors++;
        end
        verify_counters("alias_policy", 0);
        end_test("alias_policy", start_err);

        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0 && errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* compile.f */
rtl/hazard_pkg.sv
rtl/id_decode.sv
rtl/stage_tracker.sv
rtl/hazard_detect.sv
rtl/hazard_cfg_regs.sv
rtl/hazard_top.sv
bench/tb_hazard.sv

/* run_sim.sh */
#!/bin/sh
# builds the hazard detector testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_hazard -o tb_hazard_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_hazard_sim)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "^Simulation passed$"; then
    exit 0
fi

echo "pass message not found"
exit 1
